// ==== source/pipePkg.sv ====
package pipePkg;

    typedef logic [4:0]  regIdx;
    typedef logic [31:0] dataWord;

    typedef enum logic [5:0] {
        opNop  = 6'd0,
        opAdd  = 6'd1,
        opSub  = 6'd2,
        opAnd  = 6'd3,
        opOr   = 6'd4,
        opAddi = 6'd5,
        opLw   = 6'd6,
        opSw   = 6'd7
    } opCode;

    // Register form, used by ADD SUB AND OR
    typedef struct packed {
        opCode       op;
        regIdx       rd;
        regIdx       rs1;
        regIdx       rs2;
        logic [10:0] pad;
    } rView;

    // Immediate form, used by ADDI LW SW
    // For SW the rd field names the stored register
    typedef struct packed {
        opCode              op;
        regIdx              rd;
        regIdx              rs1;
        logic signed [15:0] imm;
    } iView;

    typedef union packed {
        rView r;
        iView i;
    } instrWord;

    typedef enum logic [1:0] {
        fromReg   = 2'b00,
        fromMemWb = 2'b01,
        fromExMem = 2'b10
    } fwdSel;

    typedef struct packed {
        logic  idNeedRs1;
        logic  idNeedRs2;
        regIdx idRs1;
        regIdx idRs2;
        logic  idIsStore;
        logic  exRegWrite;
        logic  exIsLoad;
        logic  exIsStore;
        regIdx exRd;
        regIdx exStoreReg;
        logic  wbRegWrite;
        logic  wbIsLoad;
        regIdx wbRd;
    } hazardInfo;

    typedef struct packed {
        fwdSel op1Sel;
        fwdSel op2Sel;
        logic  storeDataFwd;
        logic  stall;
    } fwdCtrl;

    typedef struct packed {
        logic    valid;
        regIdx   rd;
        dataWord value;
    } retireEvent;

    typedef struct packed {
        logic       valid;
        logic [5:0] addr;
        dataWord    data;
    } storeEvent;

    //////////////////////////////
    // Pipeline stage registers
    //////////////////////////////

    typedef struct packed {
        logic     valid;
        instrWord word;
    } fetchStage;

    typedef struct packed {
        opCode   op;
        regIdx   rd;
        regIdx   rs1;
        regIdx   rs2;
        logic    needRs1;
        logic    needRs2;
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
        logic    useImm;
        dataWord rs1Val;
        dataWord rs2Val;
        dataWord imm;
    } idExStage;

    typedef struct packed {
        logic    regWrite;
        logic    isLoad;
        logic    isStore;
        regIdx   rd;
        regIdx   storeReg;
        dataWord aluOut;
        dataWord storeData;
    } exMemStage;

    typedef struct packed {
        logic    regWrite;
        logic    isLoad;
        regIdx   rd;
        dataWord value;
    } memWbStage;

endpackage

// ==== source/instrIntake.sv ====
`timescale 1ns/1ns

module instrIntake import pipePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     instrReq,
    input  instrWord instrWordIn,
    output logic     instrAck,
    input  logic     full,
    output logic     pushValid,
    output instrWord pushWord
);

    typedef enum logic {
        stIdle,
        stAcked
    } intakeState;

    intakeState state;

    // Word is taken on the same edge that raises ack
    assign pushValid = (state == stIdle) && instrReq && !full;
    assign pushWord  = instrWordIn;
    assign instrAck  = (state == stAcked);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (pushValid) begin
                        state <= stAcked;
                    end
                end
                stAcked: begin
                    // Hold ack until the source lets go of req
                    if (!instrReq) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    //////////////////////////////
    // Handshake checks
    //////////////////////////////

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst)
        $rose(instrAck) |-> instrReq);

endmodule

// ==== source/instrQueue.sv ====
`timescale 1ns/1ns

module instrQueue import pipePkg::*; #(
    parameter int QueueDepth = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     pushValid,
    input  instrWord pushWord,
    output logic     full,
    input  logic     pop,
    output instrWord popWord,
    output logic     empty
);

    localparam int PtrBits   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountBits = $clog2(QueueDepth + 1);

    instrWord             slots [QueueDepth];
    logic [PtrBits-1:0]   wrPtr;
    logic [PtrBits-1:0]   rdPtr;
    logic [CountBits-1:0] count;

    function automatic logic [PtrBits-1:0] nextPtr(logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == CountBits'(QueueDepth));
    assign empty   = (count == '0);
    assign popWord = slots[rdPtr];

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (pushValid) begin
            slots[wrPtr] <= pushWord;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Simultaneous push and pop leaves count alone
            if (pushValid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !pushValid) begin
                count <= count - 1'b1;
            end
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        pushValid |-> !full);

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

// ==== source/forwardUnit.sv ====
`timescale 1ns/1ns

module forwardUnit import pipePkg::*; (
    input  hazardInfo hazard,
    output fwdCtrl    ctrl
);

    logic loadHitsRs1;
    logic loadHitsRs2;
    logic loadInMem;

    // Operand source for one EX operand
    // A load in EX/MEM has no data yet, so it never forwards from there
    function automatic fwdSel pickSource(logic need, regIdx src, hazardInfo h);
        fwdSel sel;
        sel = fromReg;
        if (need && (src != '0)) begin
            if (h.exRegWrite && !h.exIsLoad && (h.exRd == src)) begin
                sel = fromExMem;
            end else if (h.wbRegWrite && (h.wbRd == src)) begin
                sel = fromMemWb;
            end
        end
        return sel;
    endfunction

    //////////////////////////////
    // Load-use detection
    //////////////////////////////

    assign loadInMem = hazard.exIsLoad && hazard.exRegWrite && (hazard.exRd != '0);

    assign loadHitsRs1 = loadInMem && hazard.idNeedRs1 && (hazard.exRd == hazard.idRs1);
    assign loadHitsRs2 = loadInMem && hazard.idNeedRs2 && (hazard.exRd == hazard.idRs2);

    always_comb begin
        ctrl.op1Sel = pickSource(hazard.idNeedRs1, hazard.idRs1, hazard);
        ctrl.op2Sel = pickSource(hazard.idNeedRs2, hazard.idRs2, hazard);

        // Load in WB feeding the data of a store in MEM
        ctrl.storeDataFwd = hazard.exIsStore
                         && hazard.wbIsLoad
                         && hazard.wbRegWrite
                         && (hazard.wbRd != '0)
                         && (hazard.wbRd == hazard.exStoreReg);

        // Store data alone is picked up later in MEM, so no stall for it
        ctrl.stall = loadHitsRs1 || (loadHitsRs2 && !hazard.idIsStore);
    end

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ns

module regFile import pipePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regIdx   rdAddrA,
    input  regIdx   rdAddrB,
    output dataWord rdDataA,
    output dataWord rdDataB,
    input  logic    wrEn,
    input  regIdx   wrAddr,
    input  dataWord wrData
);

    dataWord regs [32];

    // r0 reads zero, a same-cycle write is passed straight through
    function automatic dataWord readPort(regIdx addr, dataWord stored, logic we,
                                         regIdx wa, dataWord wd);
        if (addr == '0) begin
            return '0;
        end else if (we && (wa == addr)) begin
            return wd;
        end
        return stored;
    endfunction

    assign rdDataA = readPort(rdAddrA, regs[rdAddrA], wrEn, wrAddr, wrData);
    assign rdDataB = readPort(rdAddrB, regs[rdAddrB], wrEn, wrAddr, wrData);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

endmodule

// ==== source/pipeCore.sv ====
`timescale 1ns/1ns

module pipeCore import pipePkg::*; #(
    parameter int MemWords = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  instrWord   popWord,
    input  logic       empty,
    output logic       pop,
    output hazardInfo  hazard,
    input  fwdCtrl     ctrl,
    output retireEvent retireOut,
    output storeEvent  storeOut
);

    localparam int AddrBits = $clog2(MemWords);

    fetchStage           ifId;
    idExStage            idEx;
    idExStage            idNext;
    exMemStage           exMem;
    exMemStage           exNext;
    memWbStage           memWb;
    memWbStage           wbNext;
    regIdx               readRs2;
    dataWord             rdDataA;
    dataWord             rdDataB;
    dataWord             op1;
    dataWord             op2;
    dataWord             aluB;
    dataWord             storeValue;
    logic [AddrBits-1:0] memAddr;
    dataWord             dataMem [MemWords];

    function automatic dataWord pickOperand(fwdSel sel, dataWord regVal,
                                            dataWord exVal, dataWord wbVal);
        case (sel)
            fromExMem: return exVal;
            fromMemWb: return wbVal;
            default:   return regVal;
        endcase
    endfunction

    //////////////////////////////
    // IF
    //////////////////////////////

    assign pop = !empty && !ctrl.stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            ifId <= '0;
        end else if (!ctrl.stall) begin
            ifId.valid <= pop;
            ifId.word  <= pop ? popWord : '0;
        end
    end

    //////////////////////////////
    // ID
    //////////////////////////////

    // SW carries its data register in the rd field
    assign readRs2 = (ifId.word.r.op == opSw) ? ifId.word.i.rd : ifId.word.r.rs2;

    regFile regFile_i (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (ifId.word.r.rs1),
        .rdAddrB (readRs2),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (memWb.regWrite),
        .wrAddr  (memWb.rd),
        .wrData  (memWb.value)
    );

    always_comb begin
        idNext        = '0;
        idNext.rd     = ifId.word.r.rd;
        idNext.rs1    = ifId.word.r.rs1;
        idNext.rs2    = readRs2;
        idNext.imm    = {{16{ifId.word.i.imm[15]}}, ifId.word.i.imm};
        idNext.rs1Val = rdDataA;
        idNext.rs2Val = rdDataB;
        if (ifId.valid) begin
            idNext.op = ifId.word.r.op;
            case (ifId.word.r.op)
                opAdd, opSub, opAnd, opOr: begin
                    idNext.needRs1  = 1'b1;
                    idNext.needRs2  = 1'b1;
                    idNext.regWrite = 1'b1;
                end
                opAddi: begin
                    idNext.needRs1  = 1'b1;
                    idNext.useImm   = 1'b1;
                    idNext.regWrite = 1'b1;
                end
                opLw: begin
                    idNext.needRs1  = 1'b1;
                    idNext.useImm   = 1'b1;
                    idNext.regWrite = 1'b1;
                    idNext.isLoad   = 1'b1;
                end
                opSw: begin
                    idNext.needRs1 = 1'b1;
                    idNext.needRs2 = 1'b1;
                    idNext.useImm  = 1'b1;
                    idNext.isStore = 1'b1;
                end
                default: begin
                    idNext.op = opNop;
                end
            endcase
        end
    end

    // On a stall EX keeps its instruction but picks up forwarded values,
    // since the older producer leaves the pipe during the stall
    always_ff @(posedge clk) begin
        if (rst) begin
            idEx <= '0;
        end else if (ctrl.stall) begin
            idEx.rs1Val <= op1;
            idEx.rs2Val <= op2;
        end else begin
            idEx <= idNext;
        end
    end

    //////////////////////////////
    // EX
    //////////////////////////////

    assign op1  = pickOperand(ctrl.op1Sel, idEx.rs1Val, exMem.aluOut, memWb.value);
    assign op2  = pickOperand(ctrl.op2Sel, idEx.rs2Val, exMem.aluOut, memWb.value);
    assign aluB = idEx.useImm ? idEx.imm : op2;

    always_comb begin
        exNext           = '0;
        exNext.regWrite  = idEx.regWrite;
        exNext.isLoad    = idEx.isLoad;
        exNext.isStore   = idEx.isStore;
        exNext.rd        = idEx.rd;
        exNext.storeReg  = idEx.rs2;
        exNext.storeData = op2;
        case (idEx.op)
            opSub:   exNext.aluOut = op1 - aluB;
            opAnd:   exNext.aluOut = op1 & aluB;
            opOr:    exNext.aluOut = op1 | aluB;
            default: exNext.aluOut = op1 + aluB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem <= '0;
        end else if (ctrl.stall) begin
            exMem <= '0;
        end else begin
            exMem <= exNext;
        end
    end

    //////////////////////////////
    // MEM and WB
    //////////////////////////////

    assign memAddr    = exMem.aluOut[AddrBits-1:0];
    assign storeValue = ctrl.storeDataFwd ? memWb.value : exMem.storeData;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MemWords; i++) begin
                dataMem[i] <= '0;
            end
        end else if (exMem.isStore) begin
            dataMem[memAddr] <= storeValue;
        end
    end

    always_comb begin
        wbNext          = '0;
        wbNext.regWrite = exMem.regWrite;
        wbNext.isLoad   = exMem.isLoad;
        wbNext.rd       = exMem.rd;
        wbNext.value    = exMem.isLoad ? dataMem[memAddr] : exMem.aluOut;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb <= '0;
        end else begin
            memWb <= wbNext;
        end
    end

    // Hazard view for the forwarding unit
    always_comb begin
        hazard.idNeedRs1  = idEx.needRs1;
        hazard.idNeedRs2  = idEx.needRs2;
        hazard.idRs1      = idEx.rs1;
        hazard.idRs2      = idEx.rs2;
        hazard.idIsStore  = idEx.isStore;
        hazard.exRegWrite = exMem.regWrite;
        hazard.exIsLoad   = exMem.isLoad;
        hazard.exIsStore  = exMem.isStore;
        hazard.exRd       = exMem.rd;
        hazard.exStoreReg = exMem.storeReg;
        hazard.wbRegWrite = memWb.regWrite;
        hazard.wbIsLoad   = memWb.isLoad;
        hazard.wbRd       = memWb.rd;
    end

    always_comb begin
        storeOut.valid  = exMem.isStore;
        storeOut.addr   = exMem.aluOut[5:0];
        storeOut.data   = storeValue;
        retireOut.valid = memWb.regWrite && (memWb.rd != '0);
        retireOut.rd    = memWb.rd;
        retireOut.value = memWb.value;
    end

    // After a stall the slot behind EX is empty and the load result comes from WB
    bubbleAfterStall: assert property (@(posedge clk) disable iff (rst)
        ctrl.stall |=> (!exMem.regWrite && !exMem.isStore && memWb.isLoad
                        && (ctrl.op1Sel == fromMemWb || ctrl.op2Sel == fromMemWb)));

endmodule

// ==== source/pipeTop.sv ====
`timescale 1ns/1ns

module pipeTop import pipePkg::*; #(
    parameter int QueueDepth = 4,
    parameter int MemWords   = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       instrReq,
    input  instrWord   instrWordIn,
    output logic       instrAck,
    output retireEvent retireOut,
    output storeEvent  storeOut
);

    logic      pushValid;
    logic      full;
    logic      pop;
    logic      empty;
    instrWord  pushWord;
    instrWord  popWord;
    hazardInfo hazard;
    fwdCtrl    ctrl;

    instrIntake intake_i (
        .clk         (clk),
        .rst         (rst),
        .instrReq    (instrReq),
        .instrWordIn (instrWordIn),
        .instrAck    (instrAck),
        .full        (full),
        .pushValid   (pushValid),
        .pushWord    (pushWord)
    );

    instrQueue #(
        .QueueDepth (QueueDepth)
    ) queue_i (
        .clk       (clk),
        .rst       (rst),
        .pushValid (pushValid),
        .pushWord  (pushWord),
        .full      (full),
        .pop       (pop),
        .popWord   (popWord),
        .empty     (empty)
    );

    pipeCore #(
        .MemWords (MemWords)
    ) core_i (
        .clk       (clk),
        .rst       (rst),
        .popWord   (popWord),
        .empty     (empty),
        .pop       (pop),
        .hazard    (hazard),
        .ctrl      (ctrl),
        .retireOut (retireOut),
        .storeOut  (storeOut)
    );

    forwardUnit fwd_i (
        .hazard (hazard),
        .ctrl   (ctrl)
    );

endmodule

// ==== dv/pipeModel.svh ====
`ifndef PIPE_MODEL_SVH
`define PIPE_MODEL_SVH

// Architectural state, one instruction at a time in program order
dataWord    modelRegs [32];
dataWord    modelMem  [64];
retireEvent expRetire [$];
storeEvent  expStore  [$];

function automatic void resetModel();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        modelMem[i] = '0;
    end
    expRetire.delete();
    expStore.delete();
endfunction

function automatic dataWord readReg(regIdx r);
    return (r == 5'd0) ? 32'd0 : modelRegs[r];
endfunction

// r0 drops the write and gives no retire event
function automatic void writeReg(regIdx r, dataWord v);
    retireEvent ev;
    if (r != 5'd0) begin
        modelRegs[r] = v;
        ev.valid = 1'b1;
        ev.rd    = r;
        ev.value = v;
        expRetire.push_back(ev);
    end
endfunction

function automatic void executeModel(instrWord w);
    dataWord    a;
    dataWord    b;
    dataWord    imm;
    logic [5:0] addr;
    storeEvent  ev;
    a    = readReg(w.r.rs1);
    b    = readReg(w.r.rs2);
    imm  = {{16{w.i.imm[15]}}, w.i.imm};
    // Word address wraps at 64
    addr = 6'(a + imm);
    case (w.r.op)
        opAdd:  writeReg(w.r.rd, a + b);
        opSub:  writeReg(w.r.rd, a - b);
        opAnd:  writeReg(w.r.rd, a & b);
        opOr:   writeReg(w.r.rd, a | b);
        opAddi: writeReg(w.i.rd, a + imm);
        opLw:   writeReg(w.i.rd, modelMem[addr]);
        opSw: begin
            ev.valid       = 1'b1;
            ev.addr        = addr;
            ev.data        = readReg(w.i.rd);
            modelMem[addr] = ev.data;
            expStore.push_back(ev);
        end
        default: ;
    endcase
endfunction

`endif

// ==== dv/pipeTb.sv ====
`timescale 1ns/1ns

module pipeTb import pipePkg::*; ();

    localparam int QueueDepth = 4;
    localparam int MemWords   = 64;
    localparam int AckLimit   = 40;
    localparam int DrainLimit = 200;

    logic       clk = 1'b0;
    logic       rst;
    logic       instrReq;
    instrWord   instrWordIn;
    logic       instrAck;
    retireEvent retireOut;
    storeEvent  storeOut;

    string testName;
    bit    timedOut;
    int    testChecks;
    int    testErrors;
    int    testCount;
    int    totalChecks;
    int    totalErrors;

    `include "pipeModel.svh"

    pipeTop #(
        .QueueDepth (QueueDepth),
        .MemWords   (MemWords)
    ) pipeTop_i (
        .clk         (clk),
        .rst         (rst),
        .instrReq    (instrReq),
        .instrWordIn (instrWordIn),
        .instrAck    (instrAck),
        .retireOut   (retireOut),
        .storeOut    (storeOut)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // Program generation
    //////////////////////////////

    // Mostly r1 to r7 so hazards are dense
    function automatic regIdx randReg();
        int roll;
        roll = $urandom_range(0, 15);
        if (roll == 0) begin
            return 5'd0;
        end else if (roll == 1) begin
            return regIdx'($urandom_range(8, 31));
        end
        return regIdx'($urandom_range(1, 7));
    endfunction

    function automatic logic [15:0] randImm();
        return 16'($urandom_range(0, 127) - 64);
    endfunction

    function automatic instrWord makeInstr(opCode op, regIdx rd, regIdx rs1,
                                           regIdx rs2, logic [15:0] imm);
        instrWord w;
        w = '0;
        if (op inside {opAddi, opLw, opSw}) begin
            w.i.op  = op;
            w.i.rd  = rd;
            w.i.rs1 = rs1;
            w.i.imm = imm;
        end else begin
            w.r.op  = op;
            w.r.rd  = rd;
            w.r.rs1 = rs1;
            w.r.rs2 = rs2;
        end
        return w;
    endfunction

    function automatic instrWord randAlu(regIdx rs1);
        opCode op;
        case ($urandom_range(0, 4))
            0:       op = opAdd;
            1:       op = opSub;
            2:       op = opAnd;
            3:       op = opOr;
            default: op = opAddi;
        endcase
        return makeInstr(op, randReg(), rs1, randReg(), randImm());
    endfunction

    function automatic instrWord randAny();
        instrWord w;
        case ($urandom_range(0, 7))
            0:       w = makeInstr(opNop, 5'd0, 5'd0, 5'd0, 16'd0);
            1, 2:    w = makeInstr(opLw, randReg(), randReg(), 5'd0, randImm());
            3:       w = makeInstr(opSw, randReg(), randReg(), 5'd0, randImm());
            default: w = randAlu(randReg());
        endcase
        return w;
    endfunction

    //////////////////////////////
    // Handshake and bookkeeping
    //////////////////////////////

    task automatic pause(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic waitAck(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (!timedOut && (instrAck != level)) begin
            if (cycles == AckLimit) begin
                $display("Timeout in %s: %s did not happen within %0d cycles",
                         testName, what, AckLimit);
                timedOut = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    // One four-phase transfer, model runs at the handoff
    task automatic sendWord(input instrWord w, input int holdCycles);
        if (timedOut) return;
        @(posedge clk);
        instrWordIn <= w;
        instrReq    <= 1'b1;
        @(negedge clk);
        waitAck(1'b1, "ack rise");
        if (timedOut) return;
        executeModel(w);
        repeat (holdCycles) begin
            @(negedge clk);
            testChecks++;
            assert (instrAck) else begin
                $display("%s: ack dropped while req was still high", testName);
                testErrors++;
            end
        end
        @(posedge clk);
        instrReq <= 1'b0;
        @(negedge clk);
        waitAck(1'b0, "ack fall");
    endtask

    task automatic checkLow(input logic value, input string what);
        testChecks++;
        assert (value == 1'b0) else begin
            $display("ERROR %s %s expected 0 actual %0d", testName, what, value);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic drainEvents();
        int cycles;
        cycles = 0;
        while (!timedOut && (expRetire.size() != 0 || expStore.size() != 0)) begin
            if (cycles == DrainLimit) begin
                $display("Timeout in %s: %0d retire and %0d store events never came out",
                         testName, expRetire.size(), expStore.size());
                timedOut = 1'b1;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic finishTest();
        drainEvents();
        // A few quiet cycles to catch extra events
        pause(6);
        $display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
        testCount++;
        totalChecks += testChecks;
        totalErrors += testErrors;
    endtask

    //////////////////////////////
    // Event checkers
    //////////////////////////////

    always @(negedge clk) begin
        retireEvent expR;
        storeEvent  expS;
        if (!rst && retireOut.valid) begin
            testChecks++;
            assert (expRetire.size() != 0) else begin
                $display("%s: retire to r%0d came with none expected", testName, retireOut.rd);
                testErrors++;
            end
            if (expRetire.size() != 0) begin
                expR = expRetire.pop_front();
                assert (retireOut.rd == expR.rd && retireOut.value == expR.value) else begin
                    $display("ERROR %s retire expected r%0d=%h actual r%0d=%h", testName,
                             expR.rd, expR.value, retireOut.rd, retireOut.value);
                    testErrors++;
                end
            end
        end
        if (!rst && storeOut.valid) begin
            testChecks++;
            assert (expStore.size() != 0) else begin
                $display("%s: store to %0d came with none expected", testName, storeOut.addr);
                testErrors++;
            end
            if (expStore.size() != 0) begin
                expS = expStore.pop_front();
                assert (storeOut.addr == expS.addr && storeOut.data == expS.data) else begin
                    $display("ERROR %s store expected [%0d]=%h actual [%0d]=%h", testName,
                             expS.addr, expS.data, storeOut.addr, storeOut.data);
                    testErrors++;
                end
            end
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        instrWord word;
        regIdx    prevRd;
        regIdx    base;
        regIdx    loaded;
        int       sent;
        int       burst;
        void'($urandom(49));
        rst         = 1'b1;
        instrReq    = 1'b0;
        instrWordIn = '0;
        timedOut    = 1'b0;
        testCount   = 0;
        totalChecks = 0;
        totalErrors = 0;
        resetModel();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        startTest("resetAck");
        checkLow(instrAck, "instrAck");
        checkLow(retireOut.valid, "retire valid");
        checkLow(storeOut.valid, "store valid");
        sendWord(makeInstr(opAddi, 5'd1, 5'd0, 5'd0, 16'h0123), 2);
        finishTest();

        // Each ALU op reads the previous result
        startTest("aluForward");
        prevRd = 5'd1;
        for (int n = 0; n < 60; n++) begin
            word   = randAlu(prevRd);
            prevRd = word.r.rd;
            sendWord(word, 0);
            pause($urandom_range(0, 1));
        end
        finishTest();

        startTest("loadUse");
        for (int n = 0; n < 20; n++) begin
            base   = randReg();
            loaded = randReg();
            word   = makeInstr(opSw, randReg(), base, 5'd0, randImm());
            sendWord(word, 0);
            sendWord(makeInstr(opLw, loaded, base, 5'd0, word.i.imm), 0);
            sendWord(randAlu(loaded), 0);
            pause($urandom_range(0, 2));
        end
        finishTest();

        startTest("storeForward");
        for (int n = 0; n < 30; n++) begin
            loaded = randReg();
            sendWord(makeInstr(opLw, loaded, randReg(), 5'd0, randImm()), 0);
            sendWord(makeInstr(opSw, loaded, randReg(), 5'd0, randImm()), 0);
            pause($urandom_range(0, 2));
        end
        finishTest();

        // Bursts separated by long idle stretches
        startTest("burstGaps");
        sent = 0;
        while (sent < 159) begin
            burst = $urandom_range(4, 12);
            for (int k = 0; k < burst && sent < 159; k++) begin
                sendWord(randAny(), 0);
                sent++;
            end
            pause($urandom_range(15, 40));
        end
        finishTest();

        startTest("zeroReg");
        for (int n = 0; n < 20; n++) begin
            if (n % 2 == 0) begin
                sendWord(makeInstr(opAddi, 5'd0, randReg(), 5'd0, randImm()), 0);
            end else begin
                sendWord(makeInstr(opLw, 5'd0, randReg(), 5'd0, randImm()), 0);
            end
            sendWord(makeInstr(opAdd, randReg(), 5'd0, randReg(), 16'd0), 0);
            sendWord(makeInstr(opSw, 5'd0, randReg(), 5'd0, randImm()), 0);
        end
        finishTest();

        $display("Tests %0d, checks %0d, errors %0d, timeout %0d",
                 testCount, totalChecks, totalErrors, timedOut);
        if (timedOut || totalErrors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
source/pipePkg.sv
source/instrIntake.sv
source/instrQueue.sv
source/forwardUnit.sv
source/regFile.sv
source/pipeCore.sv
source/pipeTop.sv
dv/pipeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipeTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
